/* compile.f */
source/qspi_pkg.sv
source/fetch_sequencer.sv
source/qspi_xip_reader.sv
source/word_packer.sv
source/qspi_fetch_top.sv
tb/qspi_flash_model.sv
tb/tb_qspi_fetch.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_qspi_fetch \
		-f compile.f -o tb_qspi_fetch
	./obj_dir/tb_qspi_fetch

clean:
	rm -rf obj_dir

/* tb/tb_qspi_fetch.sv */
// Testbench for the QSPI execute-in-place fetch unit
// Runs setup, directed and LFSR driven fetches against a behavioral flash
// and compares every output word with the address content rule
module tb_qspi_fetch
    import qspi_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM = 30;

    logic        clk;
    logic        rst;
    logic        req_valid;
    fetch_req_t  req;
    logic        ready;
    logic        word_valid;
    flash_word_t word;
    qspi_pads_t  pads;
    logic [3:0]  din;
    logic [3:0]  flash_out;
    logic [3:0]  flash_oe;
    logic        flash_error;
    logic [3:0]  cmds_seen;
    logic        quad_en;
    logic [15:0] xip_reads;

    fetch_req_t  req_list[$];
    flash_word_t expect_q[$];
    flash_word_t exp_w;
    logic [31:0] lfsr_state;
    int          budget       = 0;  // Watchdog limit in cycles
    int          fetch_count  = 0;

    qspi_fetch_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .ready      (ready),
        .word_valid (word_valid),
        .word       (word),
        .pads       (pads),
        .din        (din)
    );

    qspi_flash_model flash (
        .cs_n      (pads.cs_n),
        .sclk      (pads.sclk),
        .io_out    (pads.dout),
        .io_oe     (pads.oe),
        .dq_out    (flash_out),
        .dq_oe     (flash_oe),
        .error     (flash_error),
        .cmds_seen (cmds_seen),
        .quad_en   (quad_en),
        .xip_reads (xip_reads)
    );

    // Flash wins when it drives and undriven lines float high
    assign din = (flash_oe & flash_out)
               | (~flash_oe & pads.oe & pads.dout)
               | ~(flash_oe | pads.oe);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [7:0] rule_byte(input logic [23:0] a);
        logic [7:0] hi3;
        hi3 = a[23:16] + {a[22:16], 1'b0};     // x + 2x keeps the low byte of 3x
        return a[7:0] ^ a[15:8] ^ hi3;
    endfunction

    // Reference word with the lowest address in the low byte
    function automatic flash_word_t expected_word(input logic [WORD_ADDR_W-1:0] waddr);
        flash_word_t w;
        logic [23:0] base;
        base        = {waddr, 2'b00};
        w.word_addr = waddr;
        w.data      = {rule_byte(base + 24'd3), rule_byte(base + 24'd2),
                       rule_byte(base + 24'd1), rule_byte(base)};
        return w;
    endfunction

    function automatic int words_of(input logic [LEN_W-1:0] len);
        return (len == '0) ? 256 : int'(len);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL at %0.1f ns: %s is %0h, expected %0h",
                               $realtime, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_ready();
        next_cycle();
        while (!ready) next_cycle();
    endtask

    task automatic issue_request(input fetch_req_t r);
        int i;
        wait_ready();
        req_valid = 1'b1;
        req       = r;
        for (i = 0; i < words_of(r.len); i++) begin
            expect_q.push_back(expected_word(r.addr[ADDR_W-1:2] + WORD_ADDR_W'(i)));
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    // Each fetch is one flash transfer in continuous mode
    task automatic finish_fetch();
        wait_ready();
        repeat (3) next_cycle();
        fetch_count++;
        check_equal(64'(expect_q.size()), 64'd0, "words still expected after the fetch");
        check_equal(64'(xip_reads), 64'(fetch_count), "continuous reads seen by the flash");
        check_equal(64'(cmds_seen), 64'd5, "commands with an opcode");
    endtask

    initial begin
        fetch_req_t  r;
        logic [31:0] rnd;
        int          i;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        lfsr_state = 32'd71205;
        req_list.push_back({24'h000000, 8'd1});
        req_list.push_back({24'h001230, 8'd16});
        req_list.push_back({24'hA5C3F8, 8'd8});
        for (i = 0; i < N_RANDOM; i++) begin
            rnd    = lfsr_bits(22);
            r.addr = {rnd[21:0], 2'b00};
            rnd    = lfsr_bits(3);
            r.len  = 8'(rnd[2:0]) + 8'd1;
            req_list.push_back(r);
        end
        req_list.push_back({24'h7FFFF0, 8'd4});    // Carries the stray strobe
        budget = 400 + 10 + 40;     // Setup, reset and the stray request
        for (i = 0; i < req_list.size(); i++) begin
            budget += 40 + 10 * words_of(req_list[i].len);
        end

        repeat (10) next_cycle();
        check_equal(64'(pads.cs_n), 64'd1, "cs_n in reset");
        check_equal(64'(pads.sclk), 64'd0, "sclk in reset");
        check_equal(64'(pads.oe), 64'h4, "pad enables in reset");
        check_equal(64'(ready), 64'd0, "ready in reset");
        check_equal(64'(word_valid), 64'd0, "word_valid in reset");
        rst = 1'b0;

        wait_ready();   // Setup sequence runs before the first ready
        check_equal(64'(cmds_seen), 64'd5, "setup commands before ready");
        check_equal(64'(quad_en), 64'd1, "quad enable after setup");

        for (i = 0; i < req_list.size() - 1; i++) begin
            issue_request(req_list[i]);
            finish_fetch();
        end

        // A strobe while busy must be dropped
        issue_request(req_list[req_list.size() - 1]);
        repeat (2) next_cycle();
        check_equal(64'(ready), 64'd0, "ready during a fetch");
        req_valid = 1'b1;
        req       = {24'h123450, 8'd2};
        next_cycle();
        req_valid = 1'b0;
        finish_fetch();

        $display("No errors");
        $finish;
    end

    // Comparator samples words mid cycle
    always @(negedge clk) begin
        if (word_valid) begin
            if (expect_q.size() == 0) begin
                fail_run("A word arrived while no word was expected");
            end else begin
                exp_w = expect_q.pop_front();
                check_equal(64'(word), 64'(exp_w), "output word");
            end
        end
    end

    initial begin
        @(posedge flash_error);
        fail_run("The flash model found a protocol error");
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        fail_run($sformatf("Timeout, the run did not finish within %0d cycles", budget));
    end

endmodule

/* tb/qspi_flash_model.sv */
// Behavioral QSPI flash for the fetch unit testbench
// Checks the setup command order, then answers quad reads from the content rule.
// A protocol error is printed and raised on error for the testbench to end the run
module qspi_flash_model
    import qspi_pkg::*;
(
    input  logic        cs_n,
    input  logic        sclk,
    input  logic [3:0]  io_out,
    input  logic [3:0]  io_oe,
    output logic [3:0]  dq_out,
    output logic [3:0]  dq_oe,
    output logic        error,
    output logic [3:0]  cmds_seen,
    output logic        quad_en,
    output logic [15:0] xip_reads
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_AT = 8 + DUMMY_NIBBLES;    // Quad clocks ahead of read data

    logic        active  = 1'b0;    // Inside a selected transfer
    logic        cont    = 1'b0;    // Continuous read latched by the mode byte
    logic        reading = 1'b0;
    logic        wel     = 1'b0;    // Write enable latch
    logic        qe      = 1'b0;
    logic        err     = 1'b0;
    logic [3:0]  seq_idx = 4'd0;    // Setup commands accepted so far
    logic [15:0] xip_cnt = 16'd0;
    logic [3:0]  drv_out = 4'd0;
    logic [3:0]  drv_oe  = 4'd0;
    int          edges   = 0;       // Rising sclk edges in this transfer
    int          q0      = 0;       // Edge where the quad address starts
    logic [7:0]  opcode;
    logic [7:0]  mode;
    logic [15:0] sr_data;
    logic [23:0] addr;

    assign dq_out    = drv_out;
    assign dq_oe     = drv_oe;
    assign error     = err;
    assign cmds_seen = seq_idx;
    assign quad_en   = qe;
    assign xip_reads = xip_cnt;

    // Byte at a: low ^ middle ^ 3 * high
    function automatic logic [7:0] content_byte(input logic [23:0] a);
        logic [9:0] triple;
        triple = 10'(a[23:16]) * 10'd3;
        return a[7:0] ^ a[15:8] ^ triple[7:0];
    endfunction

    function automatic logic [7:0] expected_op(input logic [3:0] idx);
        case (idx)
            4'd0:    return OP_WAKE;
            4'd1:    return OP_WRITE_EN;
            4'd2:    return OP_WRITE_SR;
            4'd3:    return OP_WRITE_DIS;
            default: return OP_QUAD_READ_IO;
        endcase
    endfunction

    task automatic report(input string msg);
        $display("Flash model at %0.1f ns: %s", $realtime, msg);
        err = 1'b1;
    endtask

    task automatic check_opcode();
        if (seq_idx > 4'd4) begin
            report($sformatf("opcode %02h sent while continuous read was expected", opcode));
        end else if (opcode != expected_op(seq_idx)) begin
            report($sformatf("expected opcode %02h, got %02h", expected_op(seq_idx), opcode));
        end else begin
            if (opcode == OP_QUAD_READ_IO) begin
                if (!qe) report("quad read refused, quad enable not set");
                reading = 1'b1;
            end
            seq_idx = seq_idx + 4'd1;
        end
    endtask

    // End of a transfer, commands take effect on deselect
    task automatic finish_transfer();
        if (reading) begin
            if (q0 == 0) xip_cnt = xip_cnt + 16'd1;
            if (edges < q0 + DATA_AT) report("read ended inside address, mode or dummy clocks");
        end else if (opcode == OP_WRITE_SR) begin
            if (!wel) report("status write without write enable");
            if (edges != 24 || sr_data != STATUS_INIT) report("wrong status write");
            qe  = sr_data[1];   // Quad enable sits in the config byte
            wel = 1'b0;
        end else begin
            if (edges != 8) report("command with a wrong clock count");
            if (opcode == OP_WRITE_EN) wel = 1'b1;
            if (opcode == OP_WRITE_DIS) wel = 1'b0;
        end
    endtask

    // Input side, sampled on rising sclk
    always @(posedge sclk or posedge cs_n) begin
        int k;
        if (cs_n) begin
            if (active) finish_transfer();
            active = 1'b0;
        end else begin
            if (!active) begin
                active  = 1'b1;
                edges   = 0;
                reading = cont;     // Continuous mode skips the opcode
                q0      = cont ? 0 : 8;
                opcode  = 8'h00;
            end
            if (edges < q0) begin
                opcode = {opcode[6:0], io_out[0]};
                if (edges == 7) check_opcode();
            end else if (!reading) begin
                sr_data = {sr_data[14:0], io_out[0]};
            end else begin
                k = edges - q0;
                if (k < 8 && io_oe != 4'b1111) report("address or mode not on all four lines");
                if (k >= 8 && io_oe != 4'b0000) report("bus not released after the mode byte");
                if (k < 6) addr = {addr[19:0], io_out};
                else if (k < 8) mode = {mode[3:0], io_out};
                if (k == 7) cont = (mode == XIP_MODE_BYTE);
            end
            edges = edges + 1;
        end
    end

    // Read data goes out on falling sclk, high nibble first
    always @(negedge sclk or posedge cs_n) begin
        int          n;
        logic [7:0]  b;
        if (cs_n) begin
            drv_oe <= 4'b0000;
        end else if (reading && edges >= q0 + DATA_AT) begin
            n = edges - (q0 + DATA_AT);
            b = content_byte(addr + 24'(n / 2));
            drv_out <= n[0] ? b[3:0] : b[7:4];
            drv_oe  <= 4'b1111;
        end
    end

endmodule

/* source/qspi_fetch_top.sv */
// Top level of the QSPI execute-in-place fetch unit
// Requests go in as a single-cycle strobe while ready is high, words come out
// as single-cycle strobes. Pads leave as separate drive, enable and input fields
module qspi_fetch_top
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  fetch_req_t  req,
    output logic        ready,
    output logic        word_valid,
    output flash_word_t word,
    output qspi_pads_t  pads,
    input  logic [3:0]  din
);

    logic                   setup_done;
    logic                   byte_valid;
    logic [7:0]             byte_data;
    logic [ADDR_W-1:0]      rd_addr;
    logic                   rd_hold;
    logic                   start;
    logic [WORD_ADDR_W-1:0] start_word_addr;

    fetch_sequencer u_seq (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req             (req),
        .ready           (ready),
        .setup_done      (setup_done),
        .byte_valid      (byte_valid),
        .rd_addr         (rd_addr),
        .rd_hold         (rd_hold),
        .start           (start),
        .start_word_addr (start_word_addr)
    );

    qspi_xip_reader u_reader (
        .clk        (clk),
        .rst        (rst),
        .rd_addr    (rd_addr),
        .rd_hold    (rd_hold),
        .setup_done (setup_done),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .pads       (pads),
        .din        (din)
    );

    // Byte strobes feed both the counter above and the packer
    word_packer u_packer (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .start_word_addr (start_word_addr),
        .byte_valid      (byte_valid),
        .byte_data       (byte_data),
        .word_valid      (word_valid),
        .word            (word)
    );

endmodule

/* source/word_packer.sv */
// Output stage of the fetch unit
// Collects flash bytes into little-endian 32-bit words and tags each
// word with its word address, starting from the address given on start
module word_packer
    import qspi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [WORD_ADDR_W-1:0] start_word_addr,
    input  logic                   byte_valid,
    input  logic [7:0]             byte_data,
    output logic                   word_valid,
    output flash_word_t            word
);

    logic [1:0]             lane;       // Byte position inside the word
    logic [23:0]            shreg;      // First three bytes, newest on top
    logic [WORD_ADDR_W-1:0] next_addr;
    logic                   word_done;

    assign word_done = byte_valid && (lane == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane       <= 2'd0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (start) begin
                lane <= 2'd0;   // Realign on every new fetch
            end else if (byte_valid) begin
                lane <= lane + 1'b1;
            end
        end
    end

    // Data and address path
    always_ff @(posedge clk) begin
        if (start) begin
            next_addr <= start_word_addr;
        end else if (byte_valid) begin
            shreg <= {byte_data, shreg[23:8]};
            if (word_done) begin
                // Lowest address ends up in bits 7:0
                word.data      <= {byte_data, shreg};
                word.word_addr <= next_addr;
                next_addr      <= next_addr + 1'b1;
            end
        end
    end

endmodule

/* source/qspi_xip_reader.sv */
// QSPI flash reader running at the host clock
// After reset it wakes the chip, sets quad enable and enters continuous quad read.
// Once setup_done is high, place an address on rd_addr and hold rd_hold high while
// sequential bytes are wanted. Drop rd_hold for a cycle before a new address.
module qspi_xip_reader
    import qspi_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              rd_hold,
    output logic              setup_done,
    output logic              byte_valid,
    output logic [7:0]        byte_data,
    output qspi_pads_t        pads,
    input  logic [3:0]        din
);

    // Bus phase of the current transfer
    typedef enum logic [2:0] {
        X_GAP,      // cs high, counting the gap or waiting for work
        X_SERIAL,   // Opcode and setup data on io0
        X_QUAD,     // Address and mode byte on all four lines
        X_DUMMY,    // Bus released, flash turns around
        X_DATA      // Flash drives read data
    } xfer_e;

    setup_step_e      step;
    xfer_e            xfer;
    logic             cs_n;
    logic [GAP_W-1:0] gap_cnt;
    logic [4:0]       bit_cnt;      // Clocks left in the current phase
    logic [39:0]      sbuf;         // Outgoing bits, always taken from the top
    logic             nib_phase;    // High while the low nibble is due
    logic [3:0]       hi_nib;

    assign setup_done = (step == STEP_READY);

    // Pin state, all of it moves on the falling clock edge
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            step    <= STEP_WAKE;
            xfer    <= X_GAP;
            cs_n    <= 1'b1;
            gap_cnt <= GAP_W'(CS_GAP_CYCLES - 1);
            bit_cnt <= '0;
            sbuf    <= '0;
        end else if (step == STEP_READY && !rd_hold && xfer != X_GAP) begin
            // Host gave up the stream, end the transfer wherever it is
            cs_n    <= 1'b1;
            xfer    <= X_GAP;
            gap_cnt <= GAP_W'(CS_GAP_CYCLES - 1);
        end else begin
            case (xfer)
                X_GAP: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (step != STEP_READY || rd_hold) begin
                        cs_n    <= 1'b0;
                        xfer    <= X_SERIAL;
                        bit_cnt <= 5'd8;    // Plain opcode length
                        case (step)
                            STEP_WAKE: sbuf <= {OP_WAKE, 32'h0};
                            STEP_WREN: sbuf <= {OP_WRITE_EN, 32'h0};
                            STEP_WRSR: begin
                                sbuf    <= {OP_WRITE_SR, STATUS_INIT, 16'h0};
                                bit_cnt <= 5'd24;   // Opcode plus two bytes
                            end
                            STEP_WRDI: sbuf <= {OP_WRITE_DIS, 32'h0};
                            STEP_FIRST_READ: begin
                                // Dummy read at address zero just to latch continuous mode
                                sbuf <= {OP_QUAD_READ_IO, 24'h0, XIP_MODE_BYTE};
                            end
                            default: begin
                                // Continuous mode, no opcode
                                sbuf <= {rd_addr, XIP_MODE_BYTE, 8'h00};
                                xfer <= X_QUAD;
                            end
                        endcase
                    end
                end
                X_SERIAL: begin
                    sbuf    <= sbuf << 1;
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == 5'd1) begin
                        if (step == STEP_FIRST_READ) begin
                            xfer    <= X_QUAD;  // Opcode done, address follows
                            bit_cnt <= 5'd8;
                        end else begin
                            cs_n    <= 1'b1;
                            xfer    <= X_GAP;
                            gap_cnt <= GAP_W'(CS_GAP_CYCLES - 1);
                            case (step)
                                STEP_WAKE: step <= STEP_WREN;
                                STEP_WREN: step <= STEP_WRSR;
                                STEP_WRSR: step <= STEP_WRDI;
                                default:   step <= STEP_FIRST_READ;
                            endcase
                        end
                    end
                end
                X_QUAD: begin
                    sbuf    <= sbuf << 4;
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == 5'd1) begin
                        xfer    <= X_DUMMY;
                        bit_cnt <= 5'(DUMMY_NIBBLES);
                    end
                end
                X_DUMMY: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == 5'd1) begin
                        if (step == STEP_FIRST_READ) begin
                            // Chip is in continuous mode now, skip the data
                            cs_n    <= 1'b1;
                            xfer    <= X_GAP;
                            gap_cnt <= GAP_W'(CS_GAP_CYCLES - 1);
                            step    <= STEP_READY;
                        end else begin
                            xfer <= X_DATA; // First nibble appears on this edge
                        end
                    end
                end
                default: begin
                    // Data streams until rd_hold drops
                end
            endcase
        end
    end

    // Pad drive follows the bus phase
    always_comb begin
        pads.cs_n = cs_n;
        pads.sclk = clk & ~cs_n;    // Flash clock only while selected
        pads.dout = 4'b0000;
        pads.oe   = 4'b0000;
        case (xfer)
            X_GAP: begin
                pads.oe = 4'b0100;  // Write protect held low when idle
            end
            X_SERIAL: begin
                pads.oe   = 4'b0001;
                pads.dout = {3'b000, sbuf[39]};
            end
            X_QUAD: begin
                pads.oe   = 4'b1111;
                pads.dout = sbuf[39:36];
            end
            default: begin
                // Dummy and data clocks leave every line to the flash
            end
        endcase
    end

    // Byte strobe, sampled on the rising edge like the flash clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nib_phase  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (xfer == X_DATA) begin
                nib_phase <= ~nib_phase;
                if (nib_phase) begin
                    byte_valid <= 1'b1;    // Second nibble completes the byte
                end
            end else begin
                nib_phase <= 1'b0;  // A cut transfer drops its half byte
            end
        end
    end

    // High nibble first
    always_ff @(posedge clk) begin
        if (xfer == X_DATA) begin
            if (nib_phase) begin
                byte_data <= {hi_nib, din};
            end else begin
                hi_nib <= din;
            end
        end
    end

endmodule

/* source/fetch_sequencer.sv */
// Request front end of the fetch unit
// Accepts one fetch while ready is high, converts the word count to bytes
// and holds the reader in sequential read until the last byte strobe
module fetch_sequencer
    import qspi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  fetch_req_t             req,
    output logic                   ready,
    input  logic                   setup_done,
    input  logic                   byte_valid,
    output logic [ADDR_W-1:0]      rd_addr,
    output logic                   rd_hold,
    output logic                   start,
    output logic [WORD_ADDR_W-1:0] start_word_addr
);

    // LOAD gives the reader one cycle of stable address with hold still low
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_FETCH
    } seq_state_e;

    seq_state_e       state;
    logic [LEN_W+2:0] byte_total;   // Up to 1024 bytes
    logic [LEN_W+2:0] byte_cnt;
    logic             accept;
    logic             last_byte;

    assign ready     = setup_done && (state == SEQ_IDLE);
    assign accept    = req_valid && ready;  // Strobes while busy are dropped here
    assign last_byte = byte_valid && (byte_cnt == byte_total - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            rd_hold  <= 1'b0;
            start    <= 1'b0;
            byte_cnt <= '0;
        end else begin
            start <= accept;    // One cycle pulse toward the packer
            case (state)
                SEQ_IDLE: begin
                    byte_cnt <= '0;
                    if (accept) begin
                        state <= SEQ_LOAD;
                    end
                end
                SEQ_LOAD: begin
                    // Address settled last cycle, now ask for bytes
                    rd_hold <= 1'b1;
                    state   <= SEQ_FETCH;
                end
                SEQ_FETCH: begin
                    if (byte_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (last_byte) begin
                        rd_hold <= 1'b0;    // Low the cycle after the final strobe
                        state   <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Request fields, captured only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_addr         <= {req.addr[ADDR_W-1:2], 2'b00};
            start_word_addr <= req.addr[ADDR_W-1:2];
            // Words to bytes, a zero count stands for 256 words
            byte_total      <= {req.len == '0, req.len, 2'b00};
        end
    end

endmodule

/* source/qspi_pkg.sv */
// Shared definitions for the QSPI execute-in-place fetch unit
// Import with a wildcard in the module header wherever a type or constant is needed

package qspi_pkg;

    // Address and request sizes
    localparam int ADDR_W      = 24;   // Flash byte address
    localparam int WORD_ADDR_W = 22;   // 32-bit word address
    localparam int LEN_W       = 8;    // Word count, zero means 256

    // Flash bus timing
    localparam int CS_GAP_CYCLES = 2;  // Minimum chip select high time between transfers
    localparam int GAP_W         = $clog2(CS_GAP_CYCLES + 1);
    localparam int DUMMY_NIBBLES = 4;  // Released bus clocks before read data

    // Mode byte that keeps the chip in continuous read
    localparam logic [7:0] XIP_MODE_BYTE = 8'h20;

    // Status then config byte, config bit 1 is quad enable
    localparam logic [15:0] STATUS_INIT = 16'h8002;

    // Flash opcodes, sent on io0 one bit per clock
    typedef enum logic [7:0] {
        OP_WAKE         = 8'hAB,
        OP_WRITE_EN     = 8'h06,
        OP_WRITE_SR     = 8'h01,
        OP_WRITE_DIS    = 8'h04,
        OP_QUAD_READ_IO = 8'hEB
    } flash_op_e;

    // Reader phases from reset to streaming reads
    typedef enum logic [2:0] {
        STEP_WAKE,
        STEP_WREN,
        STEP_WRSR,
        STEP_WRDI,
        STEP_FIRST_READ,
        STEP_READY
    } setup_step_e;

    // Fetch request, addr is word aligned
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } fetch_req_t;

    // Packed output word with its word address
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            data;
    } flash_word_t;

    // Pad side of the reader, bit order io3 hold, io2 wp, io1 so, io0 si
    typedef struct packed {
        logic       cs_n;
        logic       sclk;
        logic [3:0] dout;
        logic [3:0] oe;
    } qspi_pads_t;

endpackage
